// ==== project.f ====
+incdir+src
src/cache_axi_pkg.sv
src/read_arbiter.sv
src/write_buffer.sv
src/cache_axi_bridge.sv
test/axi_mem_model.sv
test/bridge_checker.sv
test/tb_cache_axi_bridge.sv

// ==== Makefile ====
TOP := tb_cache_axi_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f project.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F -- "** PASS **" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/tb_cache_axi_bridge.sv ====
`timescale 1ns/10ps
`include "cache_axi_defines.svh"

module tb_cache_axi_bridge;

    localparam logic [31:0] FILL_XOR = 32'h5a3c_96e1;
    localparam int N_IC = 40;
    localparam int N_DC = 60;
    // sequences times worst burst at 8 cycles per word
    localparam int NUM_SEQ = 10 + N_IC + N_DC;
    localparam int TIMEOUT_CYCLES = NUM_SEQ * `ICACHE_LINE_WORDS * 8;

    logic                         clk = 1'b0;
    logic                         reset = 1'b1;
    logic                         i_ic_rd_req, o_ic_rd_rdy, o_ic_ret_valid, o_ic_ret_last;
    logic [31:0]                  i_ic_rd_addr, o_ic_ret_data;
    logic                         i_dc_rd_req, o_dc_rd_rdy, o_dc_ret_valid, o_dc_ret_last;
    logic [31:0]                  i_dc_rd_addr, o_dc_ret_data;
    logic                         i_wr_req, o_wr_rdy;
    logic [31:0]                  i_wr_addr;
    logic [`DCACHE_LINE_BITS-1:0] i_wr_data;
    logic                         o_arvalid, o_arid, i_arready, o_rready;
    logic [31:0]                  o_araddr, i_rdata;
    logic                         i_rid, i_rlast, i_rvalid;
    logic                         o_awvalid, i_awready, o_wvalid, o_wlast, i_wready;
    logic [31:0]                  o_awaddr, o_wdata;
    logic [3:0]                   o_wstrb;
    logic                         i_bvalid, o_bready;

    int   seed = 32'hb0fd_1041;
    int   test_id = 0;
    int   other_errors = 0;
    int   expect_beats = 0;
    int   cycles = 0;
    int   checker_errors;
    int   checked_beats;
    logic grant_log = 1'b0;
    logic grant_order [$];

    always #2 clk = ~clk;

    cache_axi_bridge cache_axi_bridge_i (.*);

    axi_mem_model #(.FILL_XOR(FILL_XOR)) axi_mem_model_i (
        .clk(clk), .reset(reset),
        .i_arvalid(o_arvalid), .i_araddr(o_araddr), .i_arid(o_arid), .o_arready(i_arready),
        .o_rid(i_rid), .o_rdata(i_rdata), .o_rlast(i_rlast), .o_rvalid(i_rvalid),
        .i_rready(o_rready),
        .i_awvalid(o_awvalid), .i_awaddr(o_awaddr), .o_awready(i_awready),
        .i_wvalid(o_wvalid), .i_wdata(o_wdata),
        .i_wstrb(o_wstrb), .i_wlast(o_wlast), .o_wready(i_wready),
        .o_bvalid(i_bvalid), .i_bready(o_bready)
    );

    bridge_checker #(.FILL_XOR(FILL_XOR)) bridge_checker_i (
        .clk(clk), .reset(reset), .i_test_id(test_id),
        .i_ic_rd_rdy(o_ic_rd_rdy), .i_ic_rd_addr(i_ic_rd_addr),
        .i_ic_ret_valid(o_ic_ret_valid), .i_ic_ret_last(o_ic_ret_last),
        .i_ic_ret_data(o_ic_ret_data),
        .i_dc_rd_rdy(o_dc_rd_rdy), .i_dc_rd_addr(i_dc_rd_addr),
        .i_dc_ret_valid(o_dc_ret_valid), .i_dc_ret_last(o_dc_ret_last),
        .i_dc_ret_data(o_dc_ret_data),
        .i_wr_req(i_wr_req), .i_wr_rdy(o_wr_rdy), .i_wr_addr(i_wr_addr),
        .i_wr_data(i_wr_data), .o_errors(checker_errors), .o_beats(checked_beats)
    );

    always @(posedge clk) begin
        if (grant_log && o_ic_rd_rdy) begin
            grant_order.push_back(1'b0);
        end
        if (grant_log && o_dc_rd_rdy) begin
            grant_order.push_back(1'b1);
        end
    end

    // ic and dc lines sit in separate regions
    function automatic logic [31:0] ic_line_addr(input int r);
        return 32'h0001_0000 | {17'd0, r[9:0], 5'd0};
    endfunction

    function automatic logic [31:0] dc_line_addr(input int r);
        return 32'h0002_0000 | {22'd0, r[6:1], 4'd0};
    endfunction

    function automatic logic [`DCACHE_LINE_BITS-1:0] random_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic ic_refill(input logic [31:0] addr);
        i_ic_rd_req  = 1'b1;
        i_ic_rd_addr = addr;
        @(posedge clk);
        while (!o_ic_rd_rdy) @(posedge clk);
        #1;
        i_ic_rd_req = 1'b0;
        expect_beats += `ICACHE_LINE_WORDS;
        @(posedge clk);
        while (!o_ic_ret_last) @(posedge clk);
        #1;
    endtask

    task automatic dc_refill(input logic [31:0] addr);
        i_dc_rd_req  = 1'b1;
        i_dc_rd_addr = addr;
        @(posedge clk);
        while (!o_dc_rd_rdy) @(posedge clk);
        #1;
        i_dc_rd_req = 1'b0;
        expect_beats += `DCACHE_LINE_WORDS;
        @(posedge clk);
        while (!o_dc_ret_last) @(posedge clk);
        #1;
    endtask

    task automatic writeback(input logic [31:0] addr, input logic [`DCACHE_LINE_BITS-1:0] line);
        i_wr_req  = 1'b1;
        i_wr_addr = addr;
        i_wr_data = line;
        @(posedge clk);
        while (!o_wr_rdy) @(posedge clk);
        #1;
        i_wr_req = 1'b0;
    endtask

    task automatic dc_step();
        int r;
        r = $random(seed);
        if (r[0]) begin
            writeback(dc_line_addr(r), random_line());
        end else begin
            dc_refill(dc_line_addr(r));
        end
    endtask

    task automatic check_alternation();
        if (grant_order.size() != 6) begin
            $display("FAILED dual_refill: rd_rdy pulses expected 6 actual %0d",
                     grant_order.size());
            other_errors++;
        end else begin
            for (int k = 0; k < 6; k++) begin
                if (grant_order[k] != k[0]) begin
                    $display("FAILED dual_refill: grant %0d expected %s actual %s", k,
                             k[0] ? "dc" : "ic", grant_order[k] ? "dc" : "ic");
                    other_errors++;
                end
            end
        end
    endtask

    initial begin
        i_ic_rd_req  = 1'b0;
        i_ic_rd_addr = '0;
        i_dc_rd_req  = 1'b0;
        i_dc_rd_addr = '0;
        i_wr_req     = 1'b0;
        i_wr_addr    = '0;
        i_wr_data    = '0;
        apply_reset();
        test_id = 1;
        ic_refill(32'h0001_0000);
        test_id = 2;
        dc_refill(32'h0002_0000);
        // both keep requesting, so grants alternate from ic
        apply_reset();
        test_id = 3;
        grant_log = 1'b1;
        fork
            for (int i = 0; i < 3; i++) ic_refill(32'h0001_0400 + 32'(i * 32));
            for (int j = 0; j < 3; j++) dc_refill(32'h0002_0400 + 32'(j * 16));
        join
        grant_log = 1'b0;
        check_alternation();
        test_id = 4;
        writeback(32'h0002_0040, random_line());
        dc_refill(32'h0002_0040);
        test_id = 5;
        fork
            for (int i = 0; i < N_IC; i++) ic_refill(ic_line_addr($random(seed)));
            for (int j = 0; j < N_DC; j++) dc_step();
        join
        repeat (4) @(posedge clk);
        if (checked_beats != expect_beats) begin
            $display("FAILED beat_count: expected %0d actual %0d", expect_beats, checked_beats);
            other_errors++;
        end
        $display("errors: %0d from checker, %0d from sequences, %0d beats checked",
                 checker_errors, other_errors, checked_beats);
        if (checker_errors == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR timeout: run did not finish within %0d cycles, stuck in test %0d",
                 TIMEOUT_CYCLES, test_id);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== test/bridge_checker.sv ====
`timescale 1ns/10ps
`include "cache_axi_defines.svh"

module bridge_checker #(
    parameter logic [31:0] FILL_XOR = 32'h0
) (
    input  logic                         clk,
    input  logic                         reset,
    input  int                           i_test_id,
    input  logic                         i_ic_rd_rdy,
    input  logic [31:0]                  i_ic_rd_addr,
    input  logic                         i_ic_ret_valid,
    input  logic                         i_ic_ret_last,
    input  logic [31:0]                  i_ic_ret_data,
    input  logic                         i_dc_rd_rdy,
    input  logic [31:0]                  i_dc_rd_addr,
    input  logic                         i_dc_ret_valid,
    input  logic                         i_dc_ret_last,
    input  logic [31:0]                  i_dc_ret_data,
    input  logic                         i_wr_req,
    input  logic                         i_wr_rdy,
    input  logic [31:0]                  i_wr_addr,
    input  logic [`DCACHE_LINE_BITS-1:0] i_wr_data,
    output int                           o_errors,
    output int                           o_beats
);

    // shadow copy of every accepted writeback
    logic [31:0] shadow [logic [31:0]];
    logic [31:0] base [2];
    int          beat [2];
    logic        busy [2];
    int          errors = 0;
    int          beats = 0;

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr ^ FILL_XOR;
    endfunction

    function automatic string test_label(input int id);
        case (id)
            1: return "ic_refill";
            2: return "dc_refill";
            3: return "dual_refill";
            4: return "wb_hazard";
            5: return "random_mix";
            default: return "idle";
        endcase
    endfunction

    task automatic check_beat(input int owner, input logic [31:0] data, input logic last);
        logic [31:0] addr;
        logic [31:0] exp;
        int          words;
        words = owner ? `DCACHE_LINE_WORDS : `ICACHE_LINE_WORDS;
        if (!busy[owner]) begin
            $display("ERROR %s: %s return beat with no refill outstanding",
                     test_label(i_test_id), owner ? "dc" : "ic");
            errors++;
        end else begin
            addr = base[owner] + 32'(4 * beat[owner]);
            exp  = expected_word(addr);
            beats++;
            if (data !== exp) begin
                $display("FAILED %s: addr %h expected %h actual %h",
                         test_label(i_test_id), addr, exp, data);
                errors++;
            end
            if (last != (beat[owner] == words - 1)) begin
                $display("FAILED %s: ret_last on beat %0d expected %0b actual %0b",
                         test_label(i_test_id), beat[owner], !last, last);
                errors++;
            end
            beat[owner]++;
            if (last) begin
                busy[owner] = 1'b0;
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            busy[0] = 1'b0;
            busy[1] = 1'b0;
        end else begin
            if (i_ic_ret_valid) begin
                check_beat(0, i_ic_ret_data, i_ic_ret_last);
            end
            if (i_dc_ret_valid) begin
                check_beat(1, i_dc_ret_data, i_dc_ret_last);
            end
            if (i_ic_rd_rdy) begin
                base[0] = i_ic_rd_addr;
                beat[0] = 0;
                busy[0] = 1'b1;
            end
            if (i_dc_rd_rdy) begin
                base[1] = i_dc_rd_addr;
                beat[1] = 0;
                busy[1] = 1'b1;
            end
            if (i_wr_req && i_wr_rdy) begin
                for (int i = 0; i < `DCACHE_LINE_WORDS; i++) begin
                    shadow[i_wr_addr + 32'(4 * i)] = i_wr_data[32 * i +: 32];
                end
            end
        end
    end

    assign o_errors = errors;
    assign o_beats  = beats;

endmodule

// ==== test/axi_mem_model.sv ====
`timescale 1ns/10ps
`include "cache_axi_defines.svh"

module axi_mem_model #(
    parameter logic [31:0] FILL_XOR = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        i_arvalid,
    input  logic [31:0] i_araddr,
    input  logic        i_arid,
    output logic        o_arready,
    output logic        o_rid,
    output logic [31:0] o_rdata,
    output logic        o_rlast,
    output logic        o_rvalid,
    input  logic        i_rready,
    input  logic        i_awvalid,
    input  logic [31:0] i_awaddr,
    output logic        o_awready,
    input  logic        i_wvalid,
    input  logic [31:0] i_wdata,
    input  logic [3:0]  i_wstrb,
    input  logic        i_wlast,
    output logic        o_wready,
    output logic        o_bvalid,
    input  logic        i_bready
);

    int          seed = 32'hb0fd_1041;
    logic [31:0] mem [logic [31:0]];
    logic [31:0] rd_data_q [$];
    logic        rd_id_q [$];
    int          rd_beat = 0;
    logic [31:0] wr_addr = '0;
    int          wr_beat = 0;
    logic        have_aw = 1'b0;
    logic        b_due = 1'b0;
    logic        arready = 1'b0;
    logic        rvalid = 1'b0;
    logic        rid = 1'b0;
    logic        rlast = 1'b0;
    logic [31:0] rdata = '0;
    logic        awready = 1'b0;
    logic        wready = 1'b0;
    logic        bvalid = 1'b0;

    // unwritten words hold a fill derived from their address
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return addr ^ FILL_XOR;
    endfunction

    // byte lanes without a strobe keep their old value
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                word[8 * b +: 8] = new_word[8 * b +: 8];
            end
        end
        return word;
    endfunction

    function automatic int burst_len(input logic id);
        return id ? `DCACHE_LINE_WORDS : `ICACHE_LINE_WORDS;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            rd_data_q.delete();
            rd_id_q.delete();
            rd_beat = 0;
            have_aw = 1'b0;
            b_due   = 1'b0;
        end else begin
            // the line is read when its address is accepted
            if (i_arvalid && arready) begin
                for (int i = 0; i < burst_len(i_arid); i++) begin
                    rd_data_q.push_back(read_word(i_araddr + 32'(4 * i)));
                end
                rd_id_q.push_back(i_arid);
            end
            if (rvalid && i_rready) begin
                void'(rd_data_q.pop_front());
                if (rlast) begin
                    void'(rd_id_q.pop_front());
                    rd_beat = 0;
                end else begin
                    rd_beat++;
                end
            end
            if (bvalid && i_bready) begin
                b_due = 1'b0;
            end
            if (i_awvalid && awready) begin
                wr_addr = i_awaddr;
                wr_beat = 0;
                have_aw = 1'b1;
            end
            if (i_wvalid && wready) begin
                mem[wr_addr + 32'(4 * wr_beat)] =
                    merge_bytes(read_word(wr_addr + 32'(4 * wr_beat)), i_wdata, i_wstrb);
                wr_beat++;
                if (i_wlast) begin
                    have_aw = 1'b0;
                    b_due   = 1'b1;
                end
            end
        end
        #1;
        // random gaps on every ready and on rvalid
        arready = !reset && (($random(seed) & 3) != 0);
        awready = !reset && !have_aw && !b_due && (($random(seed) & 3) != 0);
        wready  = have_aw && (($random(seed) & 3) != 0);
        bvalid  = b_due;
        rvalid  = (rd_id_q.size() != 0) && (($random(seed) & 3) != 0);
        if (rd_id_q.size() != 0) begin
            rid   = rd_id_q[0];
            rdata = rd_data_q[0];
            rlast = (rd_beat == burst_len(rd_id_q[0]) - 1);
        end
    end

    assign o_arready = arready;
    assign o_rvalid  = rvalid;
    assign o_rid     = rid;
    assign o_rdata   = rdata;
    assign o_rlast   = rlast;
    assign o_awready = awready;
    assign o_wready  = wready;
    assign o_bvalid  = bvalid;

endmodule

// ==== src/cache_axi_bridge.sv ====
`timescale 1ns/10ps
`include "cache_axi_defines.svh"

module cache_axi_bridge (
    input  logic                         clk,
    input  logic                         reset,

    // icache refill
    input  logic                         i_ic_rd_req,
    input  logic [31:0]                  i_ic_rd_addr,
    output logic                         o_ic_rd_rdy,
    output logic                         o_ic_ret_valid,
    output logic                         o_ic_ret_last,
    output logic [31:0]                  o_ic_ret_data,

    // dcache refill
    input  logic                         i_dc_rd_req,
    input  logic [31:0]                  i_dc_rd_addr,
    output logic                         o_dc_rd_rdy,
    output logic                         o_dc_ret_valid,
    output logic                         o_dc_ret_last,
    output logic [31:0]                  o_dc_ret_data,

    // dcache writeback
    input  logic                         i_wr_req,
    input  logic [31:0]                  i_wr_addr,
    input  logic [`DCACHE_LINE_BITS-1:0] i_wr_data,
    output logic                         o_wr_rdy,

    // AXI master
    output logic                         o_arvalid,
    output logic [31:0]                  o_araddr,
    output logic                         o_arid,
    input  logic                         i_arready,
    input  logic                         i_rid,
    input  logic [31:0]                  i_rdata,
    input  logic                         i_rlast,
    input  logic                         i_rvalid,
    output logic                         o_rready,
    output logic                         o_awvalid,
    output logic [31:0]                  o_awaddr,
    input  logic                         i_awready,
    output logic                         o_wvalid,
    output logic [31:0]                  o_wdata,
    output logic [3:0]                   o_wstrb,
    output logic                         o_wlast,
    input  logic                         i_wready,
    input  logic                         i_bvalid,
    output logic                         o_bready
);

    logic        wb_pending;
    logic [31:0] wb_addr;

    read_arbiter read_arbiter_i (
        .clk            (clk),
        .reset          (reset),
        .i_ic_rd_req    (i_ic_rd_req),
        .i_ic_rd_addr   (i_ic_rd_addr),
        .i_dc_rd_req    (i_dc_rd_req),
        .i_dc_rd_addr   (i_dc_rd_addr),
        .i_wb_pending   (wb_pending),
        .i_wb_addr      (wb_addr),
        .i_arready      (i_arready),
        .i_rid          (i_rid),
        .i_rdata        (i_rdata),
        .i_rlast        (i_rlast),
        .i_rvalid       (i_rvalid),
        .o_ic_rd_rdy    (o_ic_rd_rdy),
        .o_dc_rd_rdy    (o_dc_rd_rdy),
        .o_ic_ret_valid (o_ic_ret_valid),
        .o_ic_ret_last  (o_ic_ret_last),
        .o_ic_ret_data  (o_ic_ret_data),
        .o_dc_ret_valid (o_dc_ret_valid),
        .o_dc_ret_last  (o_dc_ret_last),
        .o_dc_ret_data  (o_dc_ret_data),
        .o_arvalid      (o_arvalid),
        .o_araddr       (o_araddr),
        .o_arid         (o_arid),
        .o_rready       (o_rready)
    );

    write_buffer write_buffer_i (
        .clk          (clk),
        .reset        (reset),
        .i_wr_req     (i_wr_req),
        .i_wr_addr    (i_wr_addr),
        .i_wr_data    (i_wr_data),
        .o_wr_rdy     (o_wr_rdy),
        .i_awready    (i_awready),
        .i_wready     (i_wready),
        .i_bvalid     (i_bvalid),
        .o_awvalid    (o_awvalid),
        .o_awaddr     (o_awaddr),
        .o_wvalid     (o_wvalid),
        .o_wdata      (o_wdata),
        .o_wstrb      (o_wstrb),
        .o_wlast      (o_wlast),
        .o_bready     (o_bready),
        .o_wb_pending (wb_pending),
        .o_wb_addr    (wb_addr)
    );

endmodule

// ==== src/write_buffer.sv ====
`timescale 1ns/10ps
`include "cache_axi_defines.svh"

module write_buffer import cache_axi_pkg::*; (
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         i_wr_req,
    input  logic [31:0]                  i_wr_addr,
    input  logic [`DCACHE_LINE_BITS-1:0] i_wr_data,
    output logic                         o_wr_rdy,

    input  logic                         i_awready,
    input  logic                         i_wready,
    input  logic                         i_bvalid,

    output logic                         o_awvalid,
    output logic [31:0]                  o_awaddr,
    output logic                         o_wvalid,
    output logic [31:0]                  o_wdata,
    output logic [3:0]                   o_wstrb,
    output logic                         o_wlast,
    output logic                         o_bready,

    output logic                         o_wb_pending,
    output logic [31:0]                  o_wb_addr
);

    localparam int BEAT_W = $clog2(`DCACHE_LINE_WORDS);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`DCACHE_LINE_WORDS - 1);

    wb_state_e                    state_q;
    logic [`DCACHE_LINE_BITS-1:0] line_q;
    logic [31:0]                  addr_q;
    logic [BEAT_W-1:0]            beat_q;
    logic                         accept;
    logic                         last_beat;

    assign accept    = i_wr_req && (state_q == WB_IDLE);
    assign last_beat = (beat_q == LAST_BEAT);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= WB_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                WB_IDLE: begin
                    if (i_wr_req) begin
                        state_q <= WB_ADDR;
                        beat_q  <= '0;
                    end
                end
                WB_ADDR: begin
                    if (i_awready) begin
                        state_q <= WB_DATA;
                    end
                end
                WB_DATA: begin
                    // advance only on a W handshake
                    if (i_wready) begin
                        if (last_beat) begin
                            state_q <= WB_RESP;
                        end else begin
                            beat_q <= beat_q + 1'b1;
                        end
                    end
                end
                WB_RESP: begin
                    if (i_bvalid) begin
                        state_q <= WB_IDLE;
                    end
                end
                default: begin
                    state_q <= WB_IDLE;
                end
            endcase
        end
    end

    // line and address captured on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            line_q <= i_wr_data;
            addr_q <= i_wr_addr;
        end
    end

    assign o_wr_rdy  = (state_q == WB_IDLE);

    assign o_awvalid = (state_q == WB_ADDR);
    assign o_awaddr  = addr_q;

    // word 0 goes out first
    assign o_wvalid  = (state_q == WB_DATA);
    assign o_wdata   = line_q[beat_q * 32 +: 32];
    assign o_wstrb   = 4'hf;
    assign o_wlast   = (state_q == WB_DATA) && last_beat;

    assign o_bready  = 1'b1;

    assign o_wb_pending = (state_q != WB_IDLE);
    assign o_wb_addr    = addr_q;

endmodule

// ==== src/read_arbiter.sv ====
`timescale 1ns/10ps
`include "cache_axi_defines.svh"

module read_arbiter import cache_axi_pkg::*; (
    input  logic        clk,
    input  logic        reset,

    input  logic        i_ic_rd_req,
    input  logic [31:0] i_ic_rd_addr,
    input  logic        i_dc_rd_req,
    input  logic [31:0] i_dc_rd_addr,

    input  logic        i_wb_pending,
    input  logic [31:0] i_wb_addr,

    input  logic        i_arready,
    input  logic        i_rid,
    input  logic [31:0] i_rdata,
    input  logic        i_rlast,
    input  logic        i_rvalid,

    output logic        o_ic_rd_rdy,
    output logic        o_dc_rd_rdy,
    output logic        o_ic_ret_valid,
    output logic        o_ic_ret_last,
    output logic [31:0] o_ic_ret_data,
    output logic        o_dc_ret_valid,
    output logic        o_dc_ret_last,
    output logic [31:0] o_dc_ret_data,

    output logic        o_arvalid,
    output logic [31:0] o_araddr,
    output logic        o_arid,
    output logic        o_rready
);

    logic        arvalid_q;
    logic [31:0] araddr_q;
    owner_e      arid_q;
    owner_e      last_owner;
    logic        ic_inflight;
    logic        dc_inflight;

    logic        ic_hazard;
    logic        dc_hazard;
    logic        ic_elig;
    logic        dc_elig;
    logic        grant_ic;
    logic        grant_dc;
    logic        ar_fire;
    logic        r_ic;
    logic        r_dc;

    // hold a refill that would read around a pending writeback
    assign ic_hazard = i_wb_pending &&
        (i_ic_rd_addr[31:`HAZARD_LSB] == i_wb_addr[31:`HAZARD_LSB]);
    assign dc_hazard = i_wb_pending &&
        (i_dc_rd_addr[31:`HAZARD_LSB] == i_wb_addr[31:`HAZARD_LSB]);

    assign ic_elig = i_ic_rd_req && !ic_inflight && !ic_hazard;
    assign dc_elig = i_dc_rd_req && !dc_inflight && !dc_hazard;

    // round robin, only while AR is empty
    always_comb begin
        grant_ic = 1'b0;
        grant_dc = 1'b0;
        if (!arvalid_q) begin
            if (ic_elig && dc_elig) begin
                if (last_owner == OWNER_IC) begin
                    grant_dc = 1'b1;
                end else begin
                    grant_ic = 1'b1;
                end
            end else begin
                grant_ic = ic_elig;
                grant_dc = dc_elig;
            end
        end
    end

    assign ar_fire = arvalid_q && i_arready;

    always_ff @(posedge clk) begin
        if (reset) begin
            arvalid_q   <= 1'b0;
            last_owner  <= OWNER_DC;
            ic_inflight <= 1'b0;
            dc_inflight <= 1'b0;
        end else begin
            if (grant_ic || grant_dc) begin
                arvalid_q  <= 1'b1;
                last_owner <= grant_dc ? OWNER_DC : OWNER_IC;
            end else if (ar_fire) begin
                arvalid_q <= 1'b0;
            end

            // one burst in flight per owner
            if (ar_fire && arid_q == OWNER_IC) begin
                ic_inflight <= 1'b1;
            end else if (r_ic && i_rlast) begin
                ic_inflight <= 1'b0;
            end
            if (ar_fire && arid_q == OWNER_DC) begin
                dc_inflight <= 1'b1;
            end else if (r_dc && i_rlast) begin
                dc_inflight <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_ic || grant_dc) begin
            araddr_q <= grant_dc ? i_dc_rd_addr : i_ic_rd_addr;
            arid_q   <= grant_dc ? OWNER_DC : OWNER_IC;
        end
    end

    assign o_arvalid = arvalid_q;
    assign o_araddr  = araddr_q;
    assign o_arid    = arid_q;

    assign o_ic_rd_rdy = ar_fire && (arid_q == OWNER_IC);
    assign o_dc_rd_rdy = ar_fire && (arid_q == OWNER_DC);

    // steer R beats by RID
    assign r_ic = i_rvalid && (owner_e'(i_rid) == OWNER_IC);
    assign r_dc = i_rvalid && (owner_e'(i_rid) == OWNER_DC);

    assign o_ic_ret_valid = r_ic;
    assign o_ic_ret_last  = r_ic && i_rlast;
    assign o_ic_ret_data  = i_rdata;
    assign o_dc_ret_valid = r_dc;
    assign o_dc_ret_last  = r_dc && i_rlast;
    assign o_dc_ret_data  = i_rdata;

    assign o_rready = 1'b1;

endmodule

// ==== src/cache_axi_pkg.sv ====
package cache_axi_pkg;

    // owner of a read, also used as the 1-bit ARID/RID
    typedef enum logic [0:0] {
        OWNER_IC = 1'b0,
        OWNER_DC = 1'b1
    } owner_e;

    // writeback sequence: AW, then W beats, then B
    typedef enum logic [1:0] {
        WB_IDLE = 2'd0,
        WB_ADDR = 2'd1,
        WB_DATA = 2'd2,
        WB_RESP = 2'd3
    } wb_state_e;

endpackage

// ==== src/cache_axi_defines.svh ====
`ifndef CACHE_AXI_DEFINES_SVH
`define CACHE_AXI_DEFINES_SVH

// icache line is 32 bytes
`define ICACHE_LINE_WORDS 8

// dcache line is 16 bytes
`define DCACHE_LINE_WORDS 4
`define DCACHE_LINE_BITS 128

// read-after-write check works on 32-byte regions
`define HAZARD_LSB 5

`endif
